// ==== rtl/id_pkg.sv ====
/*
  Shared definitions for the instruction decode stage.
  Holds widths, RV32I opcode and ALU operator encodings, the instruction
  format views and the structs passed between decoder, mux and FSM.
*/
`default_nettype none

package id_pkg;

  localparam int unsigned xlen       = 32;
  localparam int unsigned reg_addr_w = 5;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'h03,
    OPCODE_OP_IMM = 7'h13,
    OPCODE_AUIPC  = 7'h17,
    OPCODE_STORE  = 7'h23,
    OPCODE_OP     = 7'h33,
    OPCODE_LUI    = 7'h37,
    OPCODE_BRANCH = 7'h63,
    OPCODE_JAL    = 7'h6f
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG_A, OP_A_CURRPC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic       {OP_B_REG_B, OP_B_IMM} op_b_sel_e;
  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_INCR_PC} imm_sel_e;
  typedef enum logic [1:0] {LSU_WORD = 2'b00, LSU_HALF = 2'b01, LSU_BYTE = 2'b10} lsu_type_e;

  //////////////////////////////////////////////////////////////////////
  // Instruction format views
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } instr_r_t;

  typedef struct packed {
    logic [11:0] imm11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } instr_i_t;

  typedef struct packed {
    logic [6:0] imm11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm4_0;
    opcode_e    opcode;
  } instr_s_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    opcode_e    opcode;
  } instr_b_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    opcode_e     opcode;
  } instr_u_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    opcode_e    opcode;
  } instr_j_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
    instr_s_t s;
    instr_b_t b;
    instr_u_t u;
    instr_j_t j;
  } instr_u;

  //////////////////////////////////////////////////////////////////////
  // Stage structs
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    alu_op_e   alu_op;
    op_a_sel_e op_a_sel;
    op_b_sel_e op_b_sel;
    imm_sel_e  imm_sel;
    logic      rf_we;
    logic      lsu_req;
    logic      lsu_we;
    lsu_type_e lsu_type;
    logic      lsu_sign_ext;
    logic      branch;
    logic      jump;
    logic      illegal;
  } dec_ctrl_t;

  typedef struct packed {
    alu_op_e         operator;
    logic [xlen-1:0] operand_a;
    logic [xlen-1:0] operand_b;
  } alu_req_t;

  typedef struct packed {
    logic            req;
    logic            we;
    lsu_type_e       data_type;
    logic            sign_ext;
    logic [xlen-1:0] wdata;
  } lsu_req_t;

endpackage

`default_nettype wire

// ==== rtl/id_decoder.sv ====
/*
  RV32I decoder for the supported subset.
  Turns the instruction word into control fields, register addresses and
  the five sign-extended immediates. Purely combinational.
*/
`default_nettype none

module id_decoder (
  input  id_pkg::instr_u                  instr_i,
  output id_pkg::dec_ctrl_t               ctrl_o,
  output logic [id_pkg::reg_addr_w-1:0]   rs1_o,
  output logic [id_pkg::reg_addr_w-1:0]   rs2_o,
  output logic [id_pkg::reg_addr_w-1:0]   rd_o,
  output logic [id_pkg::xlen-1:0]         imm_i_o,
  output logic [id_pkg::xlen-1:0]         imm_s_o,
  output logic [id_pkg::xlen-1:0]         imm_b_o,
  output logic [id_pkg::xlen-1:0]         imm_u_o,
  output logic [id_pkg::xlen-1:0]         imm_j_o
);

  logic       use_rs1;
  logic       use_rs2;
  logic [2:0] funct3;
  logic [6:0] funct7;

  // funct3/funct7 sit at the same bits in every format that has them
  assign funct3 = instr_i.r.funct3;
  assign funct7 = instr_i.r.funct7;

  // Arithmetic operator shared by OP and OP-IMM, alt selects SUB/SRA
  function automatic id_pkg::alu_op_e arith_op(logic [2:0] f3, logic alt);
    case (f3)
      3'b000:  arith_op = alt ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
      3'b001:  arith_op = id_pkg::ALU_SLL;
      3'b010:  arith_op = id_pkg::ALU_SLT;
      3'b011:  arith_op = id_pkg::ALU_SLTU;
      3'b100:  arith_op = id_pkg::ALU_XOR;
      3'b101:  arith_op = alt ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
      3'b110:  arith_op = id_pkg::ALU_OR;
      default: arith_op = id_pkg::ALU_AND;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Immediates
  //////////////////////////////////////////////////////////////////////

  assign imm_i_o = {{20{instr_i.i.imm11_0[11]}}, instr_i.i.imm11_0};
  assign imm_s_o = {{20{instr_i.s.imm11_5[6]}}, instr_i.s.imm11_5, instr_i.s.imm4_0};
  assign imm_b_o = {{19{instr_i.b.imm12}}, instr_i.b.imm12, instr_i.b.imm11,
                    instr_i.b.imm10_5, instr_i.b.imm4_1, 1'b0};
  assign imm_u_o = {instr_i.u.imm31_12, 12'b0};
  assign imm_j_o = {{11{instr_i.j.imm20}}, instr_i.j.imm20, instr_i.j.imm19_12,
                    instr_i.j.imm11, instr_i.j.imm10_1, 1'b0};

  //////////////////////////////////////////////////////////////////////
  // Control decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    ctrl_o  = '0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;

    case (instr_i.r.opcode)
      id_pkg::OPCODE_LUI: begin
        ctrl_o.op_a_sel = id_pkg::OP_A_ZERO;
        ctrl_o.op_b_sel = id_pkg::OP_B_IMM;
        ctrl_o.imm_sel  = id_pkg::IMM_U;
        ctrl_o.rf_we    = 1'b1;
      end
      id_pkg::OPCODE_AUIPC: begin
        ctrl_o.op_a_sel = id_pkg::OP_A_CURRPC;
        ctrl_o.op_b_sel = id_pkg::OP_B_IMM;
        ctrl_o.imm_sel  = id_pkg::IMM_U;
        ctrl_o.rf_we    = 1'b1;
      end
      id_pkg::OPCODE_JAL: begin
        // ALU forms the link address PC + 4
        ctrl_o.op_a_sel = id_pkg::OP_A_CURRPC;
        ctrl_o.op_b_sel = id_pkg::OP_B_IMM;
        ctrl_o.imm_sel  = id_pkg::IMM_INCR_PC;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.jump     = 1'b1;
      end
      id_pkg::OPCODE_BRANCH: begin
        ctrl_o.imm_sel = id_pkg::IMM_B;
        ctrl_o.branch  = 1'b1;
        use_rs1        = 1'b1;
        use_rs2        = 1'b1;
        case (funct3)
          3'b000:  ctrl_o.alu_op = id_pkg::ALU_EQ;
          3'b001:  ctrl_o.alu_op = id_pkg::ALU_NE;
          3'b100:  ctrl_o.alu_op = id_pkg::ALU_LT;
          3'b101:  ctrl_o.alu_op = id_pkg::ALU_GE;
          3'b110:  ctrl_o.alu_op = id_pkg::ALU_LTU;
          3'b111:  ctrl_o.alu_op = id_pkg::ALU_GEU;
          default: ctrl_o.illegal = 1'b1;
        endcase
      end
      id_pkg::OPCODE_LOAD: begin
        ctrl_o.op_b_sel     = id_pkg::OP_B_IMM;
        ctrl_o.rf_we        = 1'b1;
        ctrl_o.lsu_req      = 1'b1;
        ctrl_o.lsu_sign_ext = ~funct3[2];
        use_rs1             = 1'b1;
        case (funct3)
          3'b000, 3'b100: ctrl_o.lsu_type = id_pkg::LSU_BYTE;
          3'b001, 3'b101: ctrl_o.lsu_type = id_pkg::LSU_HALF;
          3'b010:         ctrl_o.lsu_type = id_pkg::LSU_WORD;
          default:        ctrl_o.illegal  = 1'b1;
        endcase
      end
      id_pkg::OPCODE_STORE: begin
        ctrl_o.op_b_sel = id_pkg::OP_B_IMM;
        ctrl_o.imm_sel  = id_pkg::IMM_S;
        ctrl_o.lsu_req  = 1'b1;
        ctrl_o.lsu_we   = 1'b1;
        use_rs1         = 1'b1;
        use_rs2         = 1'b1;
        case (funct3)
          3'b000:  ctrl_o.lsu_type = id_pkg::LSU_BYTE;
          3'b001:  ctrl_o.lsu_type = id_pkg::LSU_HALF;
          3'b010:  ctrl_o.lsu_type = id_pkg::LSU_WORD;
          default: ctrl_o.illegal  = 1'b1;
        endcase
      end
      id_pkg::OPCODE_OP_IMM: begin
        ctrl_o.op_b_sel = id_pkg::OP_B_IMM;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.alu_op   = arith_op(funct3, (funct3 == 3'b101) & funct7[5]);
        use_rs1         = 1'b1;
        // Shift amounts leave only funct7 0x00, or 0x20 for SRAI
        if (funct3 == 3'b001 && funct7 != 7'h00) begin
          ctrl_o.illegal = 1'b1;
        end
        if (funct3 == 3'b101 && funct7 != 7'h00 && funct7 != 7'h20) begin
          ctrl_o.illegal = 1'b1;
        end
      end
      id_pkg::OPCODE_OP: begin
        ctrl_o.rf_we  = 1'b1;
        ctrl_o.alu_op = arith_op(funct3, funct7[5]);
        use_rs1       = 1'b1;
        use_rs2       = 1'b1;
        if (!(funct7 == 7'h00 ||
              (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101)))) begin
          ctrl_o.illegal = 1'b1;
        end
      end
      default: ctrl_o.illegal = 1'b1;
    endcase

    // Illegal words carry no side effects at all
    if (ctrl_o.illegal) begin
      ctrl_o         = '0;
      ctrl_o.illegal = 1'b1;
      use_rs1        = 1'b0;
      use_rs2        = 1'b0;
    end
  end

  assign rs1_o = use_rs1 ? instr_i.r.rs1 : '0;
  assign rs2_o = use_rs2 ? instr_i.r.rs2 : '0;
  assign rd_o  = ctrl_o.rf_we ? instr_i.r.rd : '0;

endmodule

`default_nettype wire

// ==== rtl/id_operand_mux.sv ====
/*
  ALU operand and load/store request formation.
  Picks the immediate, then operands A and B, and packs the memory
  request. The request bit is passed on ungated.
*/
`default_nettype none

module id_operand_mux (
  input  id_pkg::dec_ctrl_t       ctrl_i,
  input  logic [id_pkg::xlen-1:0] pc_i,
  input  logic [id_pkg::xlen-1:0] rs1_data_i,
  input  logic [id_pkg::xlen-1:0] rs2_data_i,
  input  logic [id_pkg::xlen-1:0] imm_i_i,
  input  logic [id_pkg::xlen-1:0] imm_s_i,
  input  logic [id_pkg::xlen-1:0] imm_b_i,
  input  logic [id_pkg::xlen-1:0] imm_u_i,
  input  logic [id_pkg::xlen-1:0] imm_j_i,
  output id_pkg::alu_req_t        alu_o,
  output id_pkg::lsu_req_t        lsu_o
);

  logic [id_pkg::xlen-1:0] imm;
  logic [id_pkg::xlen-1:0] operand_a;

  always_comb begin
    case (ctrl_i.imm_sel)
      id_pkg::IMM_I:       imm = imm_i_i;
      id_pkg::IMM_S:       imm = imm_s_i;
      id_pkg::IMM_B:       imm = imm_b_i;
      id_pkg::IMM_U:       imm = imm_u_i;
      id_pkg::IMM_J:       imm = imm_j_i;
      default:             imm = 32'd4;
    endcase
  end

  always_comb begin
    case (ctrl_i.op_a_sel)
      id_pkg::OP_A_REG_A:  operand_a = rs1_data_i;
      id_pkg::OP_A_CURRPC: operand_a = pc_i;
      default:             operand_a = '0;
    endcase
  end

  // Branch compares keep register B as operand B
  assign alu_o.operator  = ctrl_i.alu_op;
  assign alu_o.operand_a = operand_a;
  assign alu_o.operand_b = (ctrl_i.op_b_sel == id_pkg::OP_B_IMM) ? imm : rs2_data_i;

  assign lsu_o.req       = ctrl_i.lsu_req;
  assign lsu_o.we        = ctrl_i.lsu_we;
  assign lsu_o.data_type = ctrl_i.lsu_type;
  assign lsu_o.sign_ext  = ctrl_i.lsu_sign_ext;
  assign lsu_o.wdata     = rs2_data_i;

endmodule

`default_nettype wire

// ==== rtl/id_ctrl_fsm.sv ====
/*
  ID stage FSM. Holds an instruction until it completes, stalling
  loads/stores until the memory response and jumps or taken branches
  for a fixed second cycle. Also drives the PC set and gated write enable.
*/
`default_nettype none

module id_ctrl_fsm (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              instr_valid_i,
  input  id_pkg::dec_ctrl_t ctrl_i,
  input  logic              branch_decision_i,
  input  logic              lsu_resp_valid_i,
  output logic              first_cycle_o,
  output logic              instr_done_o,
  output logic              pc_set_o,
  output logic              rf_we_o
);

  typedef enum logic {FIRST_CYCLE, MULTI_CYCLE} id_fsm_e;

  id_fsm_e id_fsm_q;
  id_fsm_e id_fsm_d;
  logic    stall_mem;
  logic    stall_jump;
  logic    stall_branch;
  logic    jump_set;
  logic    branch_set_d;
  logic    branch_set_q;
  logic    set_done_d;
  logic    set_done_q;

  assign first_cycle_o = instr_valid_i & (id_fsm_q == FIRST_CYCLE);

  //////////////////////////////////////////////////////////////////////
  // Next state and stalls
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    id_fsm_d     = id_fsm_q;
    stall_mem    = 1'b0;
    stall_jump   = 1'b0;
    stall_branch = 1'b0;
    jump_set     = 1'b0;
    branch_set_d = 1'b0;

    if (instr_valid_i) begin
      case (id_fsm_q)
        FIRST_CYCLE: begin
          if (ctrl_i.lsu_req) begin
            // Request goes out now, result is never back this cycle
            id_fsm_d  = MULTI_CYCLE;
            stall_mem = 1'b1;
          end else if (ctrl_i.branch) begin
            // Taken branch sets the PC next cycle from the flopped decision
            id_fsm_d     = branch_decision_i ? MULTI_CYCLE : FIRST_CYCLE;
            stall_branch = branch_decision_i;
            branch_set_d = branch_decision_i;
          end else if (ctrl_i.jump) begin
            id_fsm_d   = MULTI_CYCLE;
            stall_jump = 1'b1;
            jump_set   = 1'b1;
          end
        end
        default: begin
          if (ctrl_i.lsu_req && !lsu_resp_valid_i) begin
            stall_mem = 1'b1;
          end else begin
            id_fsm_d = FIRST_CYCLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_fsm_q <= FIRST_CYCLE;
    end else if (instr_valid_i) begin
      id_fsm_q <= id_fsm_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // PC set and completion
  //////////////////////////////////////////////////////////////////////

  // Remember a PC set already issued for the instruction in the stage
  assign set_done_d = (jump_set | branch_set_q | set_done_q) & ~instr_done_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      branch_set_q <= 1'b0;
      set_done_q   <= 1'b0;
    end else begin
      branch_set_q <= branch_set_d;
      set_done_q   <= set_done_d;
    end
  end

  assign pc_set_o     = (jump_set | branch_set_q) & ~set_done_q;
  assign instr_done_o = instr_valid_i & ~(stall_mem | stall_jump | stall_branch);
  assign rf_we_o      = ctrl_i.rf_we & instr_done_o;

endmodule

`default_nettype wire

// ==== rtl/id_stage.sv ====
/*
  Instruction decode stage top level.
  Connects decoder, operand mux and control FSM. The fetch side holds
  the instruction until instr_done_o; the memory side answers lsu_o.req
  with a lsu_resp_valid_i pulse.
*/
`default_nettype none

module id_stage (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          instr_valid_i,
  input  logic [id_pkg::xlen-1:0]       instr_i,
  input  logic [id_pkg::xlen-1:0]       pc_i,
  input  logic [id_pkg::xlen-1:0]       rf_rdata_a_i,
  input  logic [id_pkg::xlen-1:0]       rf_rdata_b_i,
  input  logic                          branch_decision_i,
  input  logic                          lsu_resp_valid_i,
  output logic [id_pkg::reg_addr_w-1:0] rf_raddr_a_o,
  output logic [id_pkg::reg_addr_w-1:0] rf_raddr_b_o,
  output logic [id_pkg::reg_addr_w-1:0] rf_waddr_o,
  output logic                          rf_we_o,
  output id_pkg::alu_req_t              alu_o,
  output id_pkg::lsu_req_t              lsu_o,
  output logic                          pc_set_o,
  output logic                          illegal_o,
  output logic                          instr_done_o
);

  id_pkg::instr_u          instr;
  id_pkg::dec_ctrl_t       ctrl;
  id_pkg::lsu_req_t        lsu_req;
  logic [id_pkg::xlen-1:0] imm_i;
  logic [id_pkg::xlen-1:0] imm_s;
  logic [id_pkg::xlen-1:0] imm_b;
  logic [id_pkg::xlen-1:0] imm_u;
  logic [id_pkg::xlen-1:0] imm_j;
  logic                    first_cycle;

  assign instr = instr_i;

  id_decoder u_decoder (
    .instr_i (instr),
    .ctrl_o  (ctrl),
    .rs1_o   (rf_raddr_a_o),
    .rs2_o   (rf_raddr_b_o),
    .rd_o    (rf_waddr_o),
    .imm_i_o (imm_i),
    .imm_s_o (imm_s),
    .imm_b_o (imm_b),
    .imm_u_o (imm_u),
    .imm_j_o (imm_j)
  );

  id_operand_mux u_operand_mux (
    .ctrl_i     (ctrl),
    .pc_i       (pc_i),
    .rs1_data_i (rf_rdata_a_i),
    .rs2_data_i (rf_rdata_b_i),
    .imm_i_i    (imm_i),
    .imm_s_i    (imm_s),
    .imm_b_i    (imm_b),
    .imm_u_i    (imm_u),
    .imm_j_i    (imm_j),
    .alu_o      (alu_o),
    .lsu_o      (lsu_req)
  );

  id_ctrl_fsm u_ctrl_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .instr_valid_i     (instr_valid_i),
    .ctrl_i            (ctrl),
    .branch_decision_i (branch_decision_i),
    .lsu_resp_valid_i  (lsu_resp_valid_i),
    .first_cycle_o     (first_cycle),
    .instr_done_o      (instr_done_o),
    .pc_set_o          (pc_set_o),
    .rf_we_o           (rf_we_o)
  );

  // Memory request only in the first cycle of the access
  always_comb begin
    lsu_o     = lsu_req;
    lsu_o.req = lsu_req.req & first_cycle;
  end

  assign illegal_o = instr_valid_i & ctrl.illegal;

endmodule

`default_nettype wire

// ==== test/tb_id_stage.sv ====
/*
  Testbench for the instruction decode stage.
  Reads instructions and expected results from test/id_golden.txt, drives
  the fetch, register file and memory sides, and checks each instruction.
*/
`default_nettype none

module tb_id_stage;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int nf        = 16;
  localparam int max_tests = 32;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          instr_valid_i;
  logic [id_pkg::xlen-1:0]       instr_i;
  logic [id_pkg::xlen-1:0]       pc_i;
  logic [id_pkg::xlen-1:0]       rf_rdata_a_i;
  logic [id_pkg::xlen-1:0]       rf_rdata_b_i;
  logic                          branch_decision_i;
  logic                          lsu_resp_valid_i;
  logic [id_pkg::reg_addr_w-1:0] rf_raddr_a_o;
  logic [id_pkg::reg_addr_w-1:0] rf_raddr_b_o;
  logic [id_pkg::reg_addr_w-1:0] rf_waddr_o;
  logic                          rf_we_o;
  id_pkg::alu_req_t              alu_o;
  id_pkg::lsu_req_t              lsu_o;
  logic                          pc_set_o;
  logic                          illegal_o;
  logic                          instr_done_o;

  logic [31:0] regs [0:31];
  logic [31:0] golden [0:nf*max_tests-1];
  string       names [0:18];
  int          seed;
  int          num_tests;
  int          max_delay;
  int          limit_cycles;
  int          resp_delay;
  int          test_errs;
  int          pass_count;
  int          fail_count;

  id_stage dut (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .instr_valid_i     (instr_valid_i),
    .instr_i           (instr_i),
    .pc_i              (pc_i),
    .rf_rdata_a_i      (rf_rdata_a_i),
    .rf_rdata_b_i      (rf_rdata_b_i),
    .branch_decision_i (branch_decision_i),
    .lsu_resp_valid_i  (lsu_resp_valid_i),
    .rf_raddr_a_o      (rf_raddr_a_o),
    .rf_raddr_b_o      (rf_raddr_b_o),
    .rf_waddr_o        (rf_waddr_o),
    .rf_we_o           (rf_we_o),
    .alu_o             (alu_o),
    .lsu_o             (lsu_o),
    .pc_set_o          (pc_set_o),
    .illegal_o         (illegal_o),
    .instr_done_o      (instr_done_o)
  );

  always #2 clk_i = ~clk_i;

  // Register file reads are combinational
  assign rf_rdata_a_i = regs[rf_raddr_a_o];
  assign rf_rdata_b_i = regs[rf_raddr_b_o];

  //////////////////////////////////////////////////////////////////////
  // Memory response and watchdog
  //////////////////////////////////////////////////////////////////////

  // Answer a request with a one-cycle response pulse after resp_delay cycles
  always begin
    @(negedge clk_i);
    #1;
    if (lsu_o.req) begin
      repeat (resp_delay) @(negedge clk_i);
      lsu_resp_valid_i = 1'b1;
      @(negedge clk_i);
      lsu_resp_valid_i = 1'b0;
    end
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the DUT stopped completing", limit_cycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Check helpers
  //////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string test, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
    $display("Error %s: %s expected %h actual %h", test, what, exp, act);
    test_errs++;
  endtask

  task automatic finish_test(input string test);
    if (test_errs == 0) begin
      pass_count++;
      $display("PASS %s", test);
    end else begin
      fail_count++;
      $display("FAIL %s with %0d mismatches", test, test_errs);
    end
  endtask

  // With no instruction valid every side effect must be quiet
  task automatic check_idle(input string test);
    if (instr_done_o !== 1'b0) report_mismatch(test, "idle instr_done_o", 0, 32'(instr_done_o));
    if (pc_set_o !== 1'b0) report_mismatch(test, "idle pc_set_o", 0, 32'(pc_set_o));
    if (rf_we_o !== 1'b0) report_mismatch(test, "idle rf_we_o", 0, 32'(rf_we_o));
    if (illegal_o !== 1'b0) report_mismatch(test, "idle illegal_o", 0, 32'(illegal_o));
    if (lsu_o.req !== 1'b0) report_mismatch(test, "idle lsu req", 0, 32'(lsu_o.req));
  endtask

  task automatic run_test(input int t);
    logic [31:0]                   g [0:nf-1];
    logic [7:0]                    lsu_mask;
    logic [7:0]                    pcset_mask;
    logic [id_pkg::reg_addr_w-1:0] exp_waddr;
    logic                          done_seen;
    int                            cyc;
    int                            k;
    string                         test;
    for (k = 0; k < nf; k++) begin
      g[k] = golden[t*nf + k];
    end
    test       = (g[0] < 19) ? names[g[0]] : "unnamed";
    test_errs  = 0;
    lsu_mask   = '0;
    pcset_mask = '0;
    done_seen  = 1'b0;
    cyc        = 0;
    // Only a writing instruction names a destination register
    exp_waddr  = (g[11] != 32'd0) ? g[1][11:7] : '0;

    @(negedge clk_i);
    // Preset source registers with rs1 written last
    if (g[1][24:20] != 5'd0) regs[g[1][24:20]] = g[4];
    if (g[1][19:15] != 5'd0) regs[g[1][19:15]] = g[3];
    resp_delay        = int'(g[6]);
    instr_valid_i     = 1'b1;
    instr_i           = g[1];
    pc_i              = g[2];
    branch_decision_i = g[5][0];

    while (!done_seen) begin
      #1;
      if (lsu_o.req && cyc < 8) lsu_mask[cyc] = 1'b1;
      if (pc_set_o && cyc < 8) pcset_mask[cyc] = 1'b1;
      if (rf_we_o && !instr_done_o) begin
        $display("Error %s: register write enabled before the instruction completed", test);
        test_errs++;
      end
      if (instr_done_o) begin
        done_seen = 1'b1;
        if (32'(alu_o.operator) !== g[7]) report_mismatch(test, "alu operator", g[7],
                                                          32'(alu_o.operator));
        if (alu_o.operand_a !== g[8]) report_mismatch(test, "operand a", g[8], alu_o.operand_a);
        if (alu_o.operand_b !== g[9]) report_mismatch(test, "operand b", g[9], alu_o.operand_b);
        if (32'(illegal_o) !== g[10]) report_mismatch(test, "illegal", g[10], 32'(illegal_o));
        if (32'(rf_we_o) !== g[11]) report_mismatch(test, "rf_we", g[11], 32'(rf_we_o));
        if (rf_waddr_o !== exp_waddr) report_mismatch(test, "write address", 32'(exp_waddr),
                                                      32'(rf_waddr_o));
        if (32'(cyc) !== g[15]) report_mismatch(test, "cycles to done", g[15], 32'(cyc));
        // Access attributes and store data only matter for memory ops
        if (g[12] != 32'd0) begin
          if ({lsu_o.we, lsu_o.data_type, lsu_o.sign_ext} !== g[13][3:0]) begin
            report_mismatch(test, "lsu attributes", g[13],
                            32'({lsu_o.we, lsu_o.data_type, lsu_o.sign_ext}));
          end
          if (g[13][3] && lsu_o.wdata !== g[4]) report_mismatch(test, "store data", g[4],
                                                                 lsu_o.wdata);
        end
      end else begin
        @(negedge clk_i);
        cyc++;
      end
    end
    if (32'(lsu_mask) !== g[12]) report_mismatch(test, "lsu req cycles", g[12], 32'(lsu_mask));
    if (32'(pcset_mask) !== g[14]) report_mismatch(test, "pc_set cycles", g[14],
                                                    32'(pcset_mask));

    @(negedge clk_i);
    instr_valid_i     = 1'b0;
    branch_decision_i = 1'b0;
    #1;
    check_idle(test);
    finish_test(test);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk_i             = 1'b0;
    rst_ni            = 1'b0;
    instr_valid_i     = 1'b0;
    instr_i           = '0;
    pc_i              = '0;
    branch_decision_i = 1'b0;
    lsu_resp_valid_i  = 1'b0;
    resp_delay        = 0;
    limit_cycles      = 0;
    pass_count        = 0;
    fail_count        = 0;
    seed              = 57;
    names = '{"reset_idle", "add_reg", "sub_reg", "andi_imm", "srai_imm", "sltu_reg",
              "lui", "auipc", "lw_neg_imm", "lbu_delay2", "sw_delay4", "sh_delay1",
              "jal", "beq_taken", "bltu_not_taken", "jalr_illegal", "ecall_illegal",
              "fence_illegal", "load_bad_funct3"};

    for (int r = 0; r < 32; r++) begin
      regs[r] = $random(seed);
    end
    regs[0] = '0;

    // Unread words keep an address-tagged marker with a top nibble of F
    for (int w = 0; w < nf*max_tests; w++) begin
      golden[w] = 32'hF000_0000 | 32'(w);
    end
    $readmemh("test/id_golden.txt", golden);
    num_tests = 0;
    max_delay = 0;
    while (num_tests < max_tests && golden[num_tests*nf][31:28] != 4'hF) begin
      if (int'(golden[num_tests*nf + 6]) > max_delay) max_delay = int'(golden[num_tests*nf + 6]);
      num_tests++;
    end
    limit_cycles = num_tests * (max_delay + 4) + 20;
    if (num_tests == 0) begin
      $display("No test lines could be read from the golden file");
      fail_count++;
    end

    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni    = 1'b1;
    test_errs = 0;
    repeat (2) begin
      @(negedge clk_i);
      #1;
      check_idle("reset_idle");
    end
    finish_test("reset_idle");

    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end

    $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/id_golden.txt ====
// name instr pc rs1_val rs2_val br_taken resp_delay | expected: alu_op op_a op_b illegal
// rf_we lsu_req_cycle_mask lsu_attr{we,type,sign_ext} pc_set_cycle_mask cycles_to_done
01 002081B3 00000100 11111111 22222222 0 0 0 11111111 22222222 0 1 0 0 0 0
02 404182B3 00000104 00000064 00000010 0 0 1 00000064 00000010 0 1 0 0 0 0
03 0F03F313 00000108 DEADBEEF 00000000 0 0 4 DEADBEEF 000000F0 0 1 0 0 0 0
04 4044D413 0000010C 80000000 00000000 0 0 7 80000000 00000404 0 1 0 0 0 0
05 00C5B533 00000110 00000005 FFFFFFFF 0 0 9 00000005 FFFFFFFF 0 1 0 0 0 0
06 ABCDE6B7 00000114 12345678 00000000 0 0 0 00000000 ABCDE000 0 1 0 0 0 0
07 00010717 00001000 0BADF00D 00000000 0 0 0 00001000 00010000 0 1 0 0 0 0
08 FFC82783 00000118 00002000 00000000 0 1 0 00002000 FFFFFFFC 0 1 1 1 0 1
09 00394883 0000011C 00000100 00000000 0 2 0 00000100 00000003 0 1 1 4 0 2
0A FF3A2C23 00000120 00003000 CAFEBABE 0 4 0 00003000 FFFFFFF8 0 0 1 8 0 4
0B 035B1523 00000124 00004000 00005A5A 0 1 0 00004000 0000002A 0 0 1 A 0 1
0C 010000EF 00000200 00000000 00000000 0 0 0 00000200 00000004 0 1 0 0 1 1
0D 00208463 00000204 00000055 00000055 1 0 A 00000055 00000055 0 0 0 0 2 1
0E FE41EEE3 00000208 00000009 00000003 0 0 E 00000009 00000003 0 0 0 0 0 0
0F 000100E7 0000020C 77777777 00000000 0 0 0 00000000 00000000 1 0 0 0 0 0
10 00000073 00000210 00000000 00000000 0 0 0 00000000 00000000 1 0 0 0 0 0
11 0FF0000F 00000214 00000000 00000000 0 0 0 00000000 00000000 1 0 0 0 0 0
12 0000B083 00000218 12345678 00000000 0 0 0 00000000 00000000 1 0 0 0 0 0

// ==== filelist.f ====
rtl/id_pkg.sv
rtl/id_decoder.sv
rtl/id_operand_mux.sv
rtl/id_ctrl_fsm.sv
rtl/id_stage.sv
test/tb_id_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_id_stage
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := *** TEST FAILED ***
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
